// ==== src/rv_pkg.sv ====
package rv_pkg;

    localparam int XLEN    = 32;
    localparam int REG_AW  = 5;
    localparam int SHAMT_W = $clog2(XLEN);

    // ------------------------------------------------------------------
    // opcodes and function codes

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    // selects SUB and the arithmetic right shift
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    // addi x0, x0, 0
    localparam logic [XLEN-1:0] NOP_WORD = 32'h0000_0013;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    // ------------------------------------------------------------------
    // instruction word views

    typedef struct packed {
        logic [6:0]        funct7;
        logic [REG_AW-1:0] rs2;
        logic [REG_AW-1:0] rs1;
        logic [2:0]        funct3;
        logic [REG_AW-1:0] rd;
        logic [6:0]        opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]       imm12;
        logic [REG_AW-1:0] rs1;
        logic [2:0]        funct3;
        logic [REG_AW-1:0] rd;
        logic [6:0]        opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [19:0]       imm20;
        logic [REG_AW-1:0] rd;
        logic [6:0]        opcode;
    } u_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        u_fmt_t u_fmt;
    } inst_u;

endpackage

// ==== src/stage_ifs.sv ====
`timescale 1ns/1ns

// decode to execute, registered at the end of decode
interface dec_ex_if import rv_pkg::*; ();
    alu_op_e           alu_op;
    logic [XLEN-1:0]   opnd_a;
    logic [XLEN-1:0]   opnd_b;
    logic              fwd_a;
    logic              fwd_b;
    logic [REG_AW-1:0] rd;
    logic              rd_we;
    logic              retire;

    modport src (output alu_op, opnd_a, opnd_b, fwd_a, fwd_b, rd, rd_we, retire);
    modport dst (input  alu_op, opnd_a, opnd_b, fwd_a, fwd_b, rd, rd_we, retire);
endinterface

// execute to result, combinational
interface ex_res_if import rv_pkg::*; ();
    logic              retire;
    logic              rd_we;
    logic [REG_AW-1:0] rd;
    logic [XLEN-1:0]   result;

    modport src (output retire, rd_we, rd, result);
    modport dst (input  retire, rd_we, rd, result);
endinterface

// ==== src/reg_file.sv ====
`timescale 1ns/1ns

module reg_file import rv_pkg::*; (
    input  logic              clk,
    input  logic              we,
    input  logic [REG_AW-1:0] waddr,
    input  logic [XLEN-1:0]   wdata,
    input  logic [REG_AW-1:0] raddr_a,
    input  logic [REG_AW-1:0] raddr_b,
    output logic [XLEN-1:0]   rdata_a,
    output logic [XLEN-1:0]   rdata_b
);

    // x0 has no storage
    logic [XLEN-1:0] regs [1:(2**REG_AW)-1];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

    // the writeback bus never targets x0
    a_no_x0_write: assert property (
        @(posedge clk) we |-> (waddr != '0)
    );

endmodule

// ==== src/rv_decode.sv ====
`timescale 1ns/1ns

module rv_decode import rv_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic [XLEN-1:0]   inst,
    input  logic              inst_valid,
    input  logic              wb_en,
    input  logic [REG_AW-1:0] wb_rd,
    input  logic [XLEN-1:0]   wb_data,
    dec_ex_if.src             dex
);

    inst_u           iw;
    logic [XLEN-1:0] rf_a, rf_b;
    logic [XLEN-1:0] rs1_val, rs2_val;
    logic [XLEN-1:0] imm_i, imm_u, imm;
    logic            is_alt, is_shift;
    logic            supported, use_rs1, use_rs2;
    alu_op_e         alu_op_d;

    function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
        case (f3)
            F3_ADD_SUB: alu_sel = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     alu_sel = ALU_SLL;
            F3_SLT:     alu_sel = ALU_SLT;
            F3_SLTU:    alu_sel = ALU_SLTU;
            F3_XOR:     alu_sel = ALU_XOR;
            F3_SRL_SRA: alu_sel = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      alu_sel = ALU_OR;
            F3_AND:     alu_sel = ALU_AND;
            default:    alu_sel = ALU_ADD;
        endcase
    endfunction

    // bubble in place of a missing instruction
    assign iw = inst_valid ? inst : NOP_WORD;

    reg_file u_reg_file (
        .clk     (clk),
        .we      (wb_en),
        .waddr   (wb_rd),
        .wdata   (wb_data),
        .raddr_a (iw.r_fmt.rs1),
        .raddr_b (iw.r_fmt.rs2),
        .rdata_a (rf_a),
        .rdata_b (rf_b)
    );

    // writeback bus carries the result two slots back, not yet in the file
    assign rs1_val = (wb_en && wb_rd == iw.r_fmt.rs1) ? wb_data : rf_a;
    assign rs2_val = (wb_en && wb_rd == iw.r_fmt.rs2) ? wb_data : rf_b;

    // ------------------------------------------------------------------
    // field decode

    assign imm_i    = {{(XLEN-12){iw.i_fmt.imm12[11]}}, iw.i_fmt.imm12};
    assign imm_u    = {iw.u_fmt.imm20, 12'b0};
    // funct7 view of the upper immediate bits selects SRAI
    assign is_alt   = (iw.r_fmt.funct7 == F7_ALT);
    assign is_shift = (iw.r_fmt.funct3 == F3_SLL) || (iw.r_fmt.funct3 == F3_SRL_SRA);

    always_comb begin
        supported = 1'b0;
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        alu_op_d  = ALU_ADD;
        imm       = imm_i;
        case (iw.r_fmt.opcode)
            OPC_OP: begin
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
                supported = (iw.r_fmt.funct7 == F7_BASE) ||
                            (is_alt && (iw.r_fmt.funct3 == F3_ADD_SUB ||
                                        iw.r_fmt.funct3 == F3_SRL_SRA));
                alu_op_d  = alu_sel(iw.r_fmt.funct3, is_alt);
            end
            OPC_OP_IMM: begin
                use_rs1   = 1'b1;
                supported = !is_shift || (iw.r_fmt.funct7 == F7_BASE) ||
                            (is_alt && iw.r_fmt.funct3 == F3_SRL_SRA);
                alu_op_d  = alu_sel(iw.i_fmt.funct3, is_shift && is_alt);
            end
            OPC_LUI: begin
                supported = 1'b1;
                alu_op_d  = ALU_PASS_B;
                imm       = imm_u;
            end
            default: begin
                // retires without a write
                supported = 1'b0;
            end
        endcase
    end

    // ------------------------------------------------------------------
    // decode/execute register

    always_ff @(posedge clk) begin
        if (rst) begin
            dex.rd_we  <= 1'b0;
            dex.retire <= 1'b0;
            dex.fwd_a  <= 1'b0;
            dex.fwd_b  <= 1'b0;
        end else begin
            dex.rd_we  <= supported && (iw.r_fmt.rd != '0);
            dex.retire <= inst_valid;
            // previous instruction still in execute, take its result there
            dex.fwd_a  <= use_rs1 && dex.rd_we && (dex.rd == iw.r_fmt.rs1);
            dex.fwd_b  <= use_rs2 && dex.rd_we && (dex.rd == iw.r_fmt.rs2);
        end
    end

    always_ff @(posedge clk) begin
        dex.alu_op <= alu_op_d;
        dex.opnd_a <= rs1_val;
        dex.opnd_b <= use_rs2 ? rs2_val : imm;
        dex.rd     <= iw.r_fmt.rd;
    end

    // bypass compares wb_rd alone, so a returning write never names x0
    a_no_x0_we: assert property (
        @(posedge clk) disable iff (rst) wb_en |-> (wb_rd != '0)
    );

endmodule

// ==== src/rv_execute.sv ====
`timescale 1ns/1ns

module rv_execute import rv_pkg::*; (
    dec_ex_if.dst           dex,
    input  logic [XLEN-1:0] wb_data,
    ex_res_if.src           exr
);

    logic [XLEN-1:0]    alu_a;
    logic [XLEN-1:0]    alu_b;
    logic [SHAMT_W-1:0] shamt;
    logic               lt_s;
    logic               lt_u;
    logic [XLEN-1:0]    result;

    // ------------------------------------------------------------------
    // operand forwarding

    // wb_data holds the result of the instruction just ahead
    assign alu_a = dex.fwd_a ? wb_data : dex.opnd_a;
    assign alu_b = dex.fwd_b ? wb_data : dex.opnd_b;

    // ------------------------------------------------------------------
    // alu

    assign shamt = alu_b[SHAMT_W-1:0];
    assign lt_s  = $signed(alu_a) < $signed(alu_b);
    assign lt_u  = alu_a < alu_b;

    always_comb begin
        case (dex.alu_op)
            ALU_ADD:    result = alu_a + alu_b;
            ALU_SUB:    result = alu_a - alu_b;
            ALU_SLL:    result = alu_a << shamt;
            ALU_SLT:    result = {{(XLEN-1){1'b0}}, lt_s};
            ALU_SLTU:   result = {{(XLEN-1){1'b0}}, lt_u};
            ALU_XOR:    result = alu_a ^ alu_b;
            ALU_SRL:    result = alu_a >> shamt;
            ALU_SRA:    result = $signed(alu_a) >>> shamt;
            ALU_OR:     result = alu_a | alu_b;
            ALU_AND:    result = alu_a & alu_b;
            // lui, upper immediate already placed in operand b
            ALU_PASS_B: result = alu_b;
            default:    result = '0;
        endcase
    end

    // ------------------------------------------------------------------
    // to result stage

    assign exr.retire = dex.retire;
    assign exr.rd_we  = dex.rd_we;
    assign exr.rd     = dex.rd;
    assign exr.result = result;

endmodule

// ==== src/rv_result.sv ====
`timescale 1ns/1ns

module rv_result import rv_pkg::*; #(
    parameter int RETIRE_CNT_W = 32
) (
    input  logic                    clk,
    input  logic                    rst,
    ex_res_if.dst                   exr,
    output logic                    wb_en,
    output logic [REG_AW-1:0]       wb_rd,
    output logic [XLEN-1:0]         wb_data,
    output logic [RETIRE_CNT_W-1:0] retired_cnt
);

    // control, cleared on reset
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_en       <= 1'b0;
            retired_cnt <= '0;
        end else begin
            wb_en <= exr.rd_we;
            // bubbles carry retire low and are not counted
            if (exr.retire) begin
                retired_cnt <= retired_cnt + 1'b1;
            end
        end
    end

    // writeback payload
    always_ff @(posedge clk) begin
        wb_rd   <= exr.rd;
        wb_data <= exr.result;
    end

    // a write must come from an accepted instruction
    a_wb_retired: assert property (
        @(posedge clk) disable iff (rst) wb_en |-> $past(exr.retire)
    );

endmodule

// ==== src/rv_core.sv ====
`timescale 1ns/1ns

module rv_core import rv_pkg::*; #(
    parameter int RETIRE_CNT_W = 32
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [XLEN-1:0]         inst,
    input  logic                    inst_valid,
    output logic                    wb_en,
    output logic [REG_AW-1:0]       wb_rd,
    output logic [XLEN-1:0]         wb_data,
    output logic [RETIRE_CNT_W-1:0] retired_cnt
);

    // ------------------------------------------------------------------
    // stage links

    dec_ex_if u_dex ();
    ex_res_if u_exr ();

    // ------------------------------------------------------------------
    // pipeline stages

    rv_decode u_decode (
        .clk        (clk),
        .rst        (rst),
        .inst       (inst),
        .inst_valid (inst_valid),
        .wb_en      (wb_en),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .dex        (u_dex.src)
    );

    rv_execute u_execute (
        .dex     (u_dex.dst),
        .wb_data (wb_data),
        .exr     (u_exr.src)
    );

    // writeback bus loops back to decode and execute
    rv_result #(
        .RETIRE_CNT_W (RETIRE_CNT_W)
    ) u_result (
        .clk         (clk),
        .rst         (rst),
        .exr         (u_exr.dst),
        .wb_en       (wb_en),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .retired_cnt (retired_cnt)
    );

endmodule

// ==== tb/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD_NS  = 10,
    parameter int RST_CYCLES = 3
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // reset held for a fixed number of rising edges
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// ==== tb/tb_checker.sv ====
`timescale 1ns/1ns

module tb_checker import rv_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic [XLEN-1:0]   inst,
    input  logic              inst_valid,
    input  logic              wb_en,
    input  logic [REG_AW-1:0] wb_rd,
    input  logic [XLEN-1:0]   wb_data,
    input  logic [31:0]       retired_cnt,
    output int                error_cnt,
    output int                check_cnt
);

    typedef struct packed {
        logic              we;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   data;
        logic [31:0]       cnt;
    } wb_exp_t;

    logic [XLEN-1:0] model_rf [0:31];
    wb_exp_t         exp_q [$];
    wb_exp_t         head;
    wb_exp_t         fresh;
    logic [31:0]     model_cnt;
    logic            rst_d;

    initial begin
        error_cnt = 0;
        check_cnt = 0;
        rst_d     = 1'b0;
        model_cnt = '0;
        for (int r = 0; r < 32; r++) begin
            model_rf[r] = '0;
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
        error_cnt++;
    endtask

    // rv32i arithmetic by funct3, alt picks SUB and SRA
    function automatic logic [XLEN-1:0] alu_ref(input logic [2:0] f3, input logic alt,
                                                input logic [XLEN-1:0] a, b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // one instruction in program order, updates the model registers
    function automatic wb_exp_t model_exec(input inst_u w);
        wb_exp_t         e;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic            ok;
        e  = '0;
        a  = model_rf[w.r_fmt.rs1];
        ok = 1'b0;
        case (w.r_fmt.opcode)
            OPC_OP: begin
                b  = model_rf[w.r_fmt.rs2];
                ok = (w.r_fmt.funct7 == 7'h00) ||
                     (w.r_fmt.funct7 == 7'h20 && w.r_fmt.funct3 inside {3'd0, 3'd5});
                e.data = alu_ref(w.r_fmt.funct3, w.r_fmt.funct7[5], a, b);
            end
            OPC_OP_IMM: begin
                b = {{20{w.i_fmt.imm12[11]}}, w.i_fmt.imm12};
                // shift immediates carry shamt in imm[4:0], imm[11:5] is 0 or 0x20
                if (w.i_fmt.funct3 == 3'd1) begin
                    ok = (w.i_fmt.imm12[11:5] == 7'h00);
                end else if (w.i_fmt.funct3 == 3'd5) begin
                    ok = w.i_fmt.imm12[11:5] inside {7'h00, 7'h20};
                end else begin
                    ok = 1'b1;
                end
                e.data = alu_ref(w.i_fmt.funct3, w.i_fmt.funct3 == 3'd5 && w.i_fmt.imm12[10],
                                 a, b);
            end
            OPC_LUI: begin
                ok     = 1'b1;
                e.data = {w.u_fmt.imm20, 12'h000};
            end
            default: ok = 1'b0;
        endcase
        e.rd = w.r_fmt.rd;
        e.we = ok && (e.rd != '0);
        if (e.we) begin
            model_rf[e.rd] = e.data;
        end
        return e;
    endfunction

    // ------------------------------------------------------------------
    // compare, two edges after acceptance

    always @(posedge clk) begin
        if (rst) begin
            // outputs are defined once one reset edge has passed
            if (rst_d && wb_en !== 1'b0) report_mismatch("wb_en", 0, wb_en);
            if (rst_d && retired_cnt !== '0) report_mismatch("retired_cnt", 0, retired_cnt);
            model_cnt = '0;
            exp_q.delete();
            head = '0;
            // idle slots for the two pipeline stages
            exp_q.push_back(head);
            exp_q.push_back(head);
        end else begin
            head = exp_q.pop_front();
            check_cnt++;
            if (wb_en !== head.we) report_mismatch("wb_en", head.we, wb_en);
            if (head.we && wb_rd !== head.rd) report_mismatch("wb_rd", head.rd, wb_rd);
            if (head.we && wb_data !== head.data) report_mismatch("wb_data", head.data, wb_data);
            if (retired_cnt !== head.cnt) report_mismatch("retired_cnt", head.cnt, retired_cnt);
            fresh = '0;
            if (inst_valid) begin
                model_cnt = model_cnt + 1;
                fresh     = model_exec(inst);
            end
            fresh.cnt = model_cnt;
            exp_q.push_back(fresh);
        end
        rst_d = rst;
    end

endmodule

// ==== tb/tb_top.sv ====
`timescale 1ns/1ns

module tb_top import rv_pkg::*; ();

    localparam logic [31:0] SEED      = 32'h56c4c5dd;
    localparam int          NUM_INSTS = 2000;
    localparam int          DRAIN     = 4;
    // reset, register preload, random stream and drain, with margin
    localparam int TIMEOUT_CYCLES = NUM_INSTS + 100;

    logic              clk;
    logic              rst;
    logic [XLEN-1:0]   inst;
    logic              inst_valid;
    logic              wb_en;
    logic [REG_AW-1:0] wb_rd;
    logic [XLEN-1:0]   wb_data;
    logic [31:0]       retired_cnt;
    int                error_cnt;
    int                check_cnt;
    int                cycle_cnt = 0;

    tb_clock u_clock (
        .clk (clk),
        .rst (rst)
    );

    rv_core #(
        .RETIRE_CNT_W (32)
    ) uut (
        .clk         (clk),
        .rst         (rst),
        .inst        (inst),
        .inst_valid  (inst_valid),
        .wb_en       (wb_en),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .retired_cnt (retired_cnt)
    );

    tb_checker u_checker (
        .clk         (clk),
        .rst         (rst),
        .inst        (inst),
        .inst_valid  (inst_valid),
        .wb_en       (wb_en),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .retired_cnt (retired_cnt),
        .error_cnt   (error_cnt),
        .check_cnt   (check_cnt)
    );

    // x0..x7 most of the time for close dependencies
    function automatic logic [REG_AW-1:0] pick_reg();
        if (($urandom % 8) != 0) begin
            pick_reg = REG_AW'($urandom % 8);
        end else begin
            pick_reg = REG_AW'($urandom % 32);
        end
    endfunction

    function automatic logic [XLEN-1:0] gen_inst();
        inst_u w;
        int    kind;
        int    pick;
        w    = inst_u'($urandom);
        kind = $urandom % 100;
        pick = $urandom % 10;
        w.r_fmt.rd  = pick_reg();
        w.r_fmt.rs1 = pick_reg();
        if (kind < 40) begin
            w.r_fmt.opcode = OPC_OP;
            w.r_fmt.rs2    = pick_reg();
            // mostly legal funct7, now and then a reserved one
            if (pick < 9) begin
                w.r_fmt.funct7 = (pick < 6) ? F7_BASE : F7_ALT;
            end
        end else if (kind < 80) begin
            w.i_fmt.opcode = OPC_OP_IMM;
            if (w.i_fmt.funct3 inside {F3_SLL, F3_SRL_SRA} && pick < 9) begin
                w.r_fmt.funct7 = (pick < 5) ? F7_BASE : F7_ALT;
            end
        end else if (kind < 90) begin
            w.u_fmt.opcode = OPC_LUI;
        end
        // remaining words keep a random opcode
        gen_inst = w;
    endfunction

    // ------------------------------------------------------------------
    // stimulus

    initial begin
        inst       = NOP_WORD;
        inst_valid = 1'b0;
        void'($urandom(SEED));
        while (rst) @(posedge clk);
        // addi xr, x0, imm so every register holds a defined value
        for (int r = 1; r < 32; r++) begin
            inst       <= {12'($urandom), 5'd0, F3_ADD_SUB, REG_AW'(r), OPC_OP_IMM};
            inst_valid <= 1'b1;
            @(posedge clk);
        end
        for (int i = 0; i < NUM_INSTS; i++) begin
            if (($urandom % 100) < 15) begin
                inst       <= $urandom;
                inst_valid <= 1'b0;
            end else begin
                inst       <= gen_inst();
                inst_valid <= 1'b1;
            end
            @(posedge clk);
        end
        inst_valid <= 1'b0;
        repeat (DRAIN) @(posedge clk);
        @(negedge clk);
        $display("retired %0d, checks %0d, errors %0d", retired_cnt, check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // ------------------------------------------------------------------
    // timeout

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin
        wait (cycle_cnt >= TIMEOUT_CYCLES);
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== rv_alu_core.f ====
src/rv_pkg.sv
src/stage_ifs.sv
src/reg_file.sv
src/rv_decode.sv
src/rv_execute.sv
src/rv_result.sv
src/rv_core.sv
tb/tb_clock.sv
tb/tb_checker.sv
tb/tb_top.sv

// ==== run.sh ====
#!/bin/sh
# build and run the rv_alu_core testbench with verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_top -f rv_alu_core.f -Mdir obj_dir > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/Vtb_top > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the log decides the result
if grep -q "Simulation failed" "$SIM_LOG"; then
    exit 1
fi
if ! grep -q "Simulation completed successfully" "$SIM_LOG"; then
    echo "no result line found in $SIM_LOG"
    exit 1
fi
exit 0
